// File: src.f
design/cap_id_pkg.sv
design/cap_decoder.sv
design/cap_register_file.sv
design/cap_operand_mux.sv
design/cap_writeback_mux.sv
design/cap_id_fsm.sv
design/cap_id_stage.sv
verification/cap_id_properties.sv
verification/cap_id_tb.sv

// File: verification/cap_id_tb.sv
// Testbench for the capability decode stage, applies an instruction table and checks responses
`timescale 1ns/10ps
`default_nettype none

module cap_id_tb;

  import cap_id_pkg::*;

  localparam int NumTests      = 19;
  localparam int TimeoutCycles = NumTests * 8;

  localparam logic [6:0] OpcOp    = 7'b0110011;
  localparam logic [6:0] OpcOpImm = 7'b0010011;
  localparam logic [6:0] OpcLui   = 7'b0110111;
  localparam logic [6:0] OpcLoad  = 7'b0000011;
  localparam logic [6:0] OpcStore = 7'b0100011;
  localparam logic [6:0] OpcCap   = 7'b1011011;

  localparam logic [59:0] ResMeta  = 60'h5a5_a5a5_a5a5_a5a5;
  localparam logic [59:0] LoadMeta = 60'h0c0_ffee_0c0f_fee0;
  localparam logic [59:0] PcMeta   = 60'hfed_cba9_8765_4321;
  localparam cap_t        Ddc      = {1'b1, 60'h123_4567_89ab_cdef, 32'h0000_8000};
  localparam cap_t        LoadCap  = {1'b1, LoadMeta, 32'hcafe_0000};
  localparam cap_t        NoCap    = '0;
  localparam exc_vec_t    NoExc    = '0;

  typedef enum logic [2:0] { K_NONE, K_ALU, K_MUL, K_CGET, K_CINC, K_MEM } kind_e;

  // One instruction with its stimulus and the responses it must produce
  // For CIncOffset exp_b is the offset expected on cap_b_o
  typedef struct packed {
    addr_t    instr;
    logic     pc_tag;
    kind_e    kind;
    cap_t     result;
    logic     wrote_cap;
    exc_vec_t exc_a;
    exc_vec_t exc_b;
    exc_vec_t exc_mem;
    int       done_dly;
    logic     exp_illegal;
    logic     exp_exc;
    addr_t    exp_a;
    addr_t    exp_b;
    cap_t     exp_cap;
  } entry_t;

  logic clk_i, rst_ni, instr_valid_i, instr_new_i;
  logic ex_valid_i, lsu_valid_i, cap_wrote_cap_i;
  addr_t instr_rdata_i;
  cap_t pc_cap_i, ddc_i, ex_wdata_i, lsu_wdata_i;
  exc_vec_t exc_a_i, exc_b_i, exc_mem_i;
  logic id_ready_o, illegal_insn_o, mult_en_o, cheri_exc_o, instr_ret_o;
  ex_req_t ex_req_o;
  addr_t mult_a_o, mult_b_o;
  mem_req_t mem_req_o;
  cap_op_e cap_op_o;
  logic [6:0] cap_funct_o;
  cap_t cap_a_o, cap_b_o;

  entry_t tests [NumTests];
  int n_tests = 0;
  int error_cnt = 0;
  int cycle_cnt = 0;

  cap_id_stage #(.RV32E(1'b0), .RV32M(1'b1)) u_dut (
    .clk_i(clk_i), .rst_ni(rst_ni), .instr_valid_i(instr_valid_i), .instr_new_i(instr_new_i),
    .instr_rdata_i(instr_rdata_i), .pc_cap_i(pc_cap_i), .ddc_i(ddc_i),
    .ex_valid_i(ex_valid_i), .lsu_valid_i(lsu_valid_i), .ex_wdata_i(ex_wdata_i),
    .lsu_wdata_i(lsu_wdata_i), .cap_wrote_cap_i(cap_wrote_cap_i), .exc_a_i(exc_a_i),
    .exc_b_i(exc_b_i), .exc_mem_i(exc_mem_i), .id_ready_o(id_ready_o),
    .illegal_insn_o(illegal_insn_o), .ex_req_o(ex_req_o), .mult_en_o(mult_en_o),
    .mult_a_o(mult_a_o), .mult_b_o(mult_b_o), .mem_req_o(mem_req_o), .cap_op_o(cap_op_o),
    .cap_funct_o(cap_funct_o), .cap_a_o(cap_a_o), .cap_b_o(cap_b_o),
    .cheri_exc_o(cheri_exc_o), .instr_ret_o(instr_ret_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > TimeoutCycles) begin
      $display("Timeout after %0d cycles, the stage stopped responding", cycle_cnt);
      $display("Some tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Encoding and value helpers
  ////////////////////////////////////////

  function automatic addr_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3, reg_addr_t rd, logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic addr_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                  reg_addr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // Word store
  function automatic addr_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OpcStore};
  endfunction

  // CGetAddr into x0, so only the read side matters
  function automatic addr_t cgetaddr(reg_addr_t rs1);
    return enc_r(7'h7f, 5'h0f, rs1, 3'b000, 5'd0, OpcCap);
  endfunction

  // Result as EX hands it over, with tag and junk metadata
  function automatic cap_t tagged_value(addr_t a);
    return {1'b1, ResMeta, a};
  endfunction

  function automatic cap_t untagged_int(addr_t a);
    return {1'b0, 60'h0, a};
  endfunction

  function automatic cap_op_e expected_cap_op(kind_e kind);
    case (kind)
      K_CGET:  return CAP_GETADDR;
      K_CINC:  return CAP_INCOFFSET;
      default: return CAP_NONE;
    endcase
  endfunction

  task automatic add_test(input addr_t instr, input logic pc_tag, input kind_e kind,
                          input cap_t result, input logic wrote_cap, input exc_vec_t exc_a,
                          input exc_vec_t exc_b, input exc_vec_t exc_mem, input int done_dly,
                          input logic exp_illegal, input logic exp_exc, input addr_t exp_a,
                          input addr_t exp_b, input cap_t exp_cap);
    tests[n_tests] = {instr, pc_tag, kind, result, wrote_cap, exc_a, exc_b, exc_mem,
                      done_dly, exp_illegal, exp_exc, exp_a, exp_b, exp_cap};
    n_tests++;
  endtask

  task automatic load_table();
    // ADDI x1 from x0, then ADD and ADDI reading x1
    add_test(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OpcOpImm), 1'b0, K_ALU, tagged_value(32'd5),
             1'b0, NoExc, NoExc, NoExc, 0, 1'b0, 1'b0, 32'd0, 32'd5, NoCap);
    add_test(enc_r(7'd0, 5'd1, 5'd1, 3'b000, 5'd2, OpcOp), 1'b0, K_ALU, tagged_value(32'd10),
             1'b0, NoExc, NoExc, 22'h1, 0, 1'b0, 1'b0, 32'd5, 32'd5, NoCap);
    add_test(enc_i(12'hffd, 5'd1, 3'b000, 5'd3, OpcOpImm), 1'b0, K_ALU, tagged_value(32'd2),
             1'b0, NoExc, NoExc, NoExc, 0, 1'b0, 1'b0, 32'd5, 32'hffff_fffd, NoCap);
    add_test({20'h12345, 5'd9, OpcLui}, 1'b0, K_ALU, tagged_value(32'h1234_5000),
             1'b0, NoExc, NoExc, NoExc, 0, 1'b0, 1'b0, 32'd0, 32'h1234_5000, NoCap);
    // ALU results come back untagged
    add_test(cgetaddr(5'd2), 1'b0, K_CGET, tagged_value(32'd0),
             1'b0, NoExc, NoExc, NoExc, 0, 1'b0, 1'b0, 32'd0, 32'd0, untagged_int(32'd10));
    // CIncOffset on c0 uses DDC, result kept whole
    add_test(enc_i(12'h010, 5'd0, 3'b001, 5'd4, OpcCap), 1'b0, K_CINC,
             tagged_value(32'h8010), 1'b1, NoExc, NoExc, NoExc, 0, 1'b0, 1'b0,
             32'd0, 32'h10, Ddc);
    add_test(cgetaddr(5'd4), 1'b0, K_CGET, tagged_value(32'd0), 1'b0, NoExc, NoExc, NoExc, 0,
             1'b0, 1'b0, 32'd0, 32'd0, tagged_value(32'h8010));
    // Integer-mode load is DDC relative
    add_test(enc_i(12'd8, 5'd4, 3'b010, 5'd5, OpcLoad), 1'b0, K_MEM, LoadCap,
             1'b0, NoExc, NoExc, NoExc, 3, 1'b0, 1'b0, 32'h8010, 32'd8, Ddc);
    add_test(cgetaddr(5'd5), 1'b0, K_CGET, tagged_value(32'd0),
             1'b0, NoExc, NoExc, NoExc, 0, 1'b0, 1'b0, 32'd0, 32'd0, LoadCap);
    // Capability-mode store takes x4 as base
    add_test(enc_s(12'd4, 5'd5, 5'd4), 1'b1, K_MEM, tagged_value(32'd0), 1'b0, NoExc, NoExc,
             NoExc, 3, 1'b0, 1'b0, 32'h8010, 32'd4, tagged_value(32'h8010));
    add_test(enc_r(7'd1, 5'd3, 5'd1, 3'b000, 5'd6, OpcOp), 1'b0, K_MUL, tagged_value(32'd10),
             1'b0, NoExc, NoExc, NoExc, 3, 1'b0, 1'b0, 32'd5, 32'd2, NoCap);
    add_test(cgetaddr(5'd6), 1'b0, K_CGET, tagged_value(32'd0),
             1'b0, NoExc, NoExc, NoExc, 0, 1'b0, 1'b0, 32'd0, 32'd0, untagged_int(32'd10));
    // Exception masking: unused B, trap bits only, then a real A fault
    add_test(enc_i(12'd1, 5'd1, 3'b000, 5'd7, OpcOpImm), 1'b0, K_ALU, tagged_value(32'd6),
             1'b0, NoExc, 22'h1, NoExc, 0, 1'b0, 1'b0, 32'd5, 32'd1, NoCap);
    add_test(enc_i(12'd1, 5'd1, 3'b001, 5'd8, OpcCap), 1'b0, K_CINC, tagged_value(32'h77),
             1'b0, 22'h300000, NoExc, NoExc, 0, 1'b0, 1'b0, 32'd0, 32'd1, untagged_int(32'd5));
    add_test(enc_i(12'd2, 5'd1, 3'b001, 5'd7, OpcCap), 1'b0, K_CINC, tagged_value(32'h99),
             1'b1, 22'h8, NoExc, NoExc, 0, 1'b0, 1'b1, 32'd0, 32'd2, untagged_int(32'd5));
    add_test(cgetaddr(5'd7), 1'b0, K_CGET, tagged_value(32'd0),
             1'b0, NoExc, NoExc, NoExc, 0, 1'b0, 1'b0, 32'd0, 32'd0, untagged_int(32'd6));
    add_test(cgetaddr(5'd8), 1'b0, K_CGET, tagged_value(32'd0),
             1'b0, NoExc, NoExc, NoExc, 0, 1'b0, 1'b0, 32'd0, 32'd0, untagged_int(32'h77));
    // Unknown opcode with rd = x8
    add_test(32'h0000_047f, 1'b0, K_NONE, tagged_value(32'hdead),
             1'b0, NoExc, NoExc, NoExc, 0, 1'b1, 1'b0, 32'd0, 32'd0, NoCap);
    add_test(cgetaddr(5'd8), 1'b0, K_CGET, tagged_value(32'd0),
             1'b0, NoExc, NoExc, NoExc, 0, 1'b0, 1'b0, 32'd0, 32'd0, untagged_int(32'h77));
  endtask

  ////////////////////////////////////////
  // Checks and sequencing
  ////////////////////////////////////////

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
      error_cnt++;
    end
  endtask

  task automatic compare_word(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
      error_cnt++;
    end
  endtask

  task automatic compare_cap(input string name, input cap_t got, input cap_t exp);
    if (got !== exp) begin
      $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
      error_cnt++;
    end
  endtask

  task automatic check_busy(input kind_e kind);
    compare_bit("mem_req_o.req", mem_req_o.req, kind == K_MEM);
    compare_bit("mult_en_o", mult_en_o, kind == K_MUL);
  endtask

  task automatic run_entry(input int idx);
    entry_t e;
    int     errors_before;
    int     wait_cnt;
    int     c;
    e = tests[idx];
    errors_before   = error_cnt;
    instr_new_i     = 1'b1;
    instr_rdata_i   = e.instr;
    pc_cap_i        = {e.pc_tag, PcMeta, 32'h0000_0100};
    cap_wrote_cap_i = e.wrote_cap;
    exc_a_i         = e.exc_a;
    exc_b_i         = e.exc_b;
    exc_mem_i       = e.exc_mem;
    // Wrong source selection shows up as the inverted value
    ex_wdata_i      = (e.kind == K_MEM) ? ~e.result : e.result;
    lsu_wdata_i     = (e.kind == K_MEM) ? e.result : ~e.result;

    @(negedge clk_i);
    compare_bit("illegal_insn_o", illegal_insn_o, e.exp_illegal);
    compare_bit("cheri_exc_o", cheri_exc_o, e.exp_exc);
    compare_bit("id_ready_o", id_ready_o, e.done_dly == 0);
    compare_bit("instr_ret_o", instr_ret_o, e.done_dly == 0);
    compare_word("cap_op_o", addr_t'(cap_op_o), addr_t'(expected_cap_op(e.kind)));
    check_busy(e.kind);
    if (e.kind == K_ALU || e.kind == K_MEM) begin
      compare_word("ex_req_o.operand_a", ex_req_o.operand_a, e.exp_a);
      compare_word("ex_req_o.operand_b", ex_req_o.operand_b, e.exp_b);
    end
    if (e.kind == K_MUL) begin
      compare_word("mult_a_o", mult_a_o, e.exp_a);
      compare_word("mult_b_o", mult_b_o, e.exp_b);
    end
    if (e.kind == K_CGET || e.kind == K_CINC) begin
      compare_cap("cap_a_o", cap_a_o, e.exp_cap);
    end
    if (e.kind == K_CGET) begin
      compare_word("cap_funct_o", addr_t'(cap_funct_o), 32'h7f);
    end
    if (e.kind == K_CINC) begin
      compare_cap("cap_b_o", cap_b_o, untagged_int(e.exp_b));
    end
    if (e.kind == K_MEM) begin
      compare_cap("mem_req_o.base", mem_req_o.base, e.exp_cap);
      compare_bit("mem_req_o.we", mem_req_o.we, e.instr[6:0] == OpcStore);
    end
    @(posedge clk_i);
    #1;
    instr_new_i = 1'b0;

    if (e.done_dly != 0) begin
      for (c = 1; c < e.done_dly; c++) begin
        @(negedge clk_i);
        compare_bit("id_ready_o", id_ready_o, 1'b0);
        compare_bit("instr_ret_o", instr_ret_o, 1'b0);
        check_busy(e.kind);
        @(posedge clk_i);
        #1;
      end
      ex_valid_i  = (e.kind == K_MUL);
      lsu_valid_i = (e.kind == K_MEM);
      wait_cnt = 0;
      @(negedge clk_i);
      while (!id_ready_o) begin
        wait_cnt++;
        @(negedge clk_i);
      end
      if (wait_cnt != 0) begin
        $display("id_ready_o stayed low %0d cycles after the done signal", wait_cnt);
        error_cnt++;
      end
      compare_bit("instr_ret_o", instr_ret_o, 1'b1);
      @(posedge clk_i);
      #1;
      ex_valid_i  = 1'b0;
      lsu_valid_i = 1'b0;
    end
    $display("test %0d finished with %0d errors", idx, error_cnt - errors_before);
  endtask

  initial begin
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    instr_valid_i   = 1'b0;
    instr_new_i     = 1'b0;
    instr_rdata_i   = 32'h0000_0013;
    pc_cap_i        = {1'b0, PcMeta, 32'h0000_0100};
    ddc_i           = Ddc;
    ex_valid_i      = 1'b0;
    lsu_valid_i     = 1'b0;
    ex_wdata_i      = NoCap;
    lsu_wdata_i     = NoCap;
    cap_wrote_cap_i = 1'b0;
    exc_a_i         = NoExc;
    exc_b_i         = NoExc;
    exc_mem_i       = NoExc;
    load_table();

    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    compare_bit("mem_req_o.req", mem_req_o.req, 1'b0);
    compare_bit("mult_en_o", mult_en_o, 1'b0);
    compare_bit("cheri_exc_o", cheri_exc_o, 1'b0);
    compare_bit("id_ready_o", id_ready_o, 1'b1);
    $display("reset check finished with %0d errors", error_cnt);
    @(posedge clk_i);
    #1;
    instr_valid_i = 1'b1;

    for (int i = 0; i < n_tests; i++) begin
      run_entry(i);
    end

    $display("%0d tests run, %0d errors", n_tests, error_cnt);
    if (error_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/cap_id_properties.sv
// Concurrent assertions on the decode stage top level, attached to every instance by bind
`timescale 1ns/10ps
`default_nettype none

module cap_id_properties (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 instr_valid_i,
  input logic                 instr_executing_i,
  input logic                 id_ready_i,
  input logic                 illegal_insn_i,
  input cap_id_pkg::ex_req_t  ex_req_i,
  input cap_id_pkg::mem_req_t mem_req_i,
  input logic                 mult_en_i,
  input logic                 cheri_exc_i,
  input logic                 rf_we_i
);

  // LSU and multiplier never start on the same instruction
  mem_mult_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(mem_req_i.req && mult_en_i))
    else $error("mem_req and mult_en high in the same cycle");

  // Not executing means idle with no new instruction
  ready_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !instr_executing_i |-> id_ready_i)
    else $error("id_ready low while the stage is idle");

  outputs_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_i |-> !$isunknown({id_ready_i, illegal_insn_i, ex_req_i, mem_req_i,
                                   mult_en_i, cheri_exc_i}))
    else $error("unknown value on a stage output");

  no_write_on_exc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cheri_exc_i |-> !rf_we_i)
    else $error("register write during a capability exception");

endmodule

bind cap_id_stage cap_id_properties u_properties (
  .clk_i(clk_i), .rst_ni(rst_ni), .instr_valid_i(instr_valid_i),
  .instr_executing_i(instr_executing), .id_ready_i(id_ready_o),
  .illegal_insn_i(illegal_insn_o), .ex_req_i(ex_req_o), .mem_req_i(mem_req_o),
  .mult_en_i(mult_en_o), .cheri_exc_i(cheri_exc_o), .rf_we_i(rf_we)
);

`default_nettype wire

// File: design/cap_id_stage.sv
// Top level of the capability decode stage, wires decoder, register file, muxes and FSM
`timescale 1ns/10ps
`default_nettype none

module cap_id_stage #(
  parameter bit RV32E = 1'b0,
  parameter bit RV32M = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 instr_valid_i,
  input  logic                 instr_new_i,
  input  cap_id_pkg::addr_t    instr_rdata_i,
  input  cap_id_pkg::cap_t     pc_cap_i,
  input  cap_id_pkg::cap_t     ddc_i,
  input  logic                 ex_valid_i,
  input  logic                 lsu_valid_i,
  input  cap_id_pkg::cap_t     ex_wdata_i,
  input  cap_id_pkg::cap_t     lsu_wdata_i,
  input  logic                 cap_wrote_cap_i,
  input  cap_id_pkg::exc_vec_t exc_a_i,
  input  cap_id_pkg::exc_vec_t exc_b_i,
  input  cap_id_pkg::exc_vec_t exc_mem_i,
  output logic                 id_ready_o,
  output logic                 illegal_insn_o,
  output cap_id_pkg::ex_req_t  ex_req_o,
  output logic                 mult_en_o,
  output cap_id_pkg::addr_t    mult_a_o,
  output cap_id_pkg::addr_t    mult_b_o,
  output cap_id_pkg::mem_req_t mem_req_o,
  output cap_id_pkg::cap_op_e  cap_op_o,
  output logic [6:0]           cap_funct_o,
  output cap_id_pkg::cap_t     cap_a_o,
  output cap_id_pkg::cap_t     cap_b_o,
  output logic                 cheri_exc_o,
  output logic                 instr_ret_o
);

  import cap_id_pkg::*;

  dec_ctrl_t ctrl;
  reg_addr_t raddr_a, raddr_b, waddr;
  addr_t     imm_i, imm_s, imm_u;
  cap_t      rdata_a, rdata_b, rf_wdata;
  mem_req_t  mem_req;
  logic      rf_we, wb_we, instr_executing, cap_mode;

  // PCC tag selects capability mode
  assign cap_mode       = pc_cap_i[CapW-1];
  assign illegal_insn_o = instr_valid_i & ctrl.illegal;
  assign cap_op_o       = ctrl.cap_op;
  assign mult_en_o      = instr_executing & ctrl.mult_en;

  always_comb begin
    mem_req_o     = mem_req;
    mem_req_o.req = instr_executing & ctrl.data_req;
  end

  cap_decoder #(.RV32E(RV32E), .RV32M(RV32M)) u_decoder (
    .instr_rdata_i(instr_rdata_i), .cap_mode_i(cap_mode), .ctrl_o(ctrl),
    .raddr_a_o(raddr_a), .raddr_b_o(raddr_b), .waddr_o(waddr),
    .imm_i_o(imm_i), .imm_s_o(imm_s), .imm_u_o(imm_u), .cap_funct_o(cap_funct_o)
  );

  cap_register_file #(.RV32E(RV32E)) u_register_file (
    .clk_i(clk_i), .rst_ni(rst_ni), .raddr_a_i(raddr_a), .raddr_b_i(raddr_b),
    .waddr_i(waddr), .wdata_i(rf_wdata), .we_i(rf_we),
    .rdata_a_o(rdata_a), .rdata_b_o(rdata_b)
  );

  cap_operand_mux u_operand_mux (
    .ctrl_i(ctrl), .raddr_a_i(raddr_a), .rdata_a_i(rdata_a), .rdata_b_i(rdata_b),
    .ddc_i(ddc_i), .pc_cap_i(pc_cap_i), .imm_i_i(imm_i), .imm_s_i(imm_s), .imm_u_i(imm_u),
    .cap_mode_i(cap_mode), .ex_req_o(ex_req_o), .mult_a_o(mult_a_o), .mult_b_o(mult_b_o),
    .mem_o(mem_req), .cap_a_o(cap_a_o), .cap_b_o(cap_b_o)
  );

  cap_writeback_mux u_writeback_mux (
    .ctrl_i(ctrl), .instr_executing_i(instr_executing), .wb_we_i(wb_we),
    .ex_wdata_i(ex_wdata_i), .lsu_wdata_i(lsu_wdata_i), .cap_wrote_cap_i(cap_wrote_cap_i),
    .exc_a_i(exc_a_i), .exc_b_i(exc_b_i), .exc_mem_i(exc_mem_i),
    .wdata_o(rf_wdata), .we_o(rf_we), .cheri_exc_o(cheri_exc_o)
  );

  cap_id_fsm u_id_fsm (
    .clk_i(clk_i), .rst_ni(rst_ni), .instr_new_i(instr_new_i), .ctrl_i(ctrl),
    .ex_valid_i(ex_valid_i), .lsu_valid_i(lsu_valid_i),
    .instr_executing_o(instr_executing), .wb_we_o(wb_we),
    .id_ready_o(id_ready_o), .instr_ret_o(instr_ret_o)
  );

endmodule

`default_nettype wire

// File: design/cap_id_fsm.sv
// ID-EX/WB stall machine, holds multicycle instructions until EX or the LSU is done
`timescale 1ns/10ps
`default_nettype none

module cap_id_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  instr_new_i,
  input  cap_id_pkg::dec_ctrl_t ctrl_i,
  input  logic                  ex_valid_i,
  input  logic                  lsu_valid_i,
  output logic                  instr_executing_o,
  output logic                  wb_we_o,
  output logic                  id_ready_o,
  output logic                  instr_ret_o
);

  import cap_id_pkg::*;

  id_fsm_e state_q, state_d;
  logic    done_q, done_d;
  logic    multicycle;
  logic    unit_done;

  assign multicycle = ctrl_i.data_req | ctrl_i.mult_en;
  assign unit_done  = ctrl_i.data_req ? lsu_valid_i : ex_valid_i;

  // Executing while new, or while a multicycle op is still pending
  assign instr_executing_o = instr_new_i | ~done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      done_q  <= 1'b1;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
    end
  end

  always_comb begin
    state_d     = state_q;
    done_d      = done_q;
    wb_we_o     = 1'b0;
    id_ready_o  = 1'b1;
    instr_ret_o = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (instr_new_i && multicycle) begin
          state_d    = WAIT_MULTICYCLE;
          done_d     = 1'b0;
          id_ready_o = 1'b0;
        end else begin
          instr_ret_o = instr_new_i;
        end
      end
      default: begin
        // Back-pressure keeps us here
        id_ready_o = unit_done;
        if (unit_done) begin
          state_d     = IDLE;
          done_d      = 1'b1;
          wb_we_o     = ctrl_i.reg_we;
          instr_ret_o = 1'b1;
        end
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/cap_writeback_mux.sv
// Register write-back selection with capability exception masking
`timescale 1ns/10ps
`default_nettype none

module cap_writeback_mux (
  input  cap_id_pkg::dec_ctrl_t ctrl_i,
  input  logic                  instr_executing_i,
  input  logic                  wb_we_i,
  input  cap_id_pkg::cap_t      ex_wdata_i,
  input  cap_id_pkg::cap_t      lsu_wdata_i,
  input  logic                  cap_wrote_cap_i,
  input  cap_id_pkg::exc_vec_t  exc_a_i,
  input  cap_id_pkg::exc_vec_t  exc_b_i,
  input  cap_id_pkg::exc_vec_t  exc_mem_i,
  output cap_id_pkg::cap_t      wdata_o,
  output logic                  we_o,
  output logic                  cheri_exc_o
);

  import cap_id_pkg::*;

  logic multicycle;

  // Plain integer results lose tag and metadata
  always_comb begin
    unique case (ctrl_i.wd_sel)
      WD_LSU:  wdata_o = lsu_wdata_i;
      WD_CAP:  wdata_o = cap_wrote_cap_i ? ex_wdata_i : null_with_addr(get_addr(ex_wdata_i));
      default: wdata_o = null_with_addr(get_addr(ex_wdata_i));
    endcase
  end

  // Trap bits never raise, operand faults only when the operand is used
  assign cheri_exc_o = (|exc_a_i[ExcW-3:0] && ctrl_i.cap_a_en)
                    || (|exc_b_i[ExcW-3:0] && ctrl_i.cap_b_en)
                    || (|exc_mem_i && ctrl_i.data_req);

  assign multicycle = ctrl_i.data_req | ctrl_i.mult_en;

  always_comb begin
    if (!instr_executing_i || ctrl_i.illegal || cheri_exc_o) begin
      we_o = 1'b0;
    end else begin
      we_o = multicycle ? wb_we_i : ctrl_i.reg_we;
    end
  end

endmodule

`default_nettype wire

// File: design/cap_operand_mux.sv
// Operand selection for the ALU, multiplier, LSU and capability ALU
`timescale 1ns/10ps
`default_nettype none

module cap_operand_mux (
  input  cap_id_pkg::dec_ctrl_t ctrl_i,
  input  cap_id_pkg::reg_addr_t raddr_a_i,
  input  cap_id_pkg::cap_t      rdata_a_i,
  input  cap_id_pkg::cap_t      rdata_b_i,
  input  cap_id_pkg::cap_t      ddc_i,
  input  cap_id_pkg::cap_t      pc_cap_i,
  input  cap_id_pkg::addr_t     imm_i_i,
  input  cap_id_pkg::addr_t     imm_s_i,
  input  cap_id_pkg::addr_t     imm_u_i,
  input  logic                  cap_mode_i,
  output cap_id_pkg::ex_req_t   ex_req_o,
  output cap_id_pkg::addr_t     mult_a_o,
  output cap_id_pkg::addr_t     mult_b_o,
  output cap_id_pkg::mem_req_t  mem_o,
  output cap_id_pkg::cap_t      cap_a_o,
  output cap_id_pkg::cap_t      cap_b_o
);

  import cap_id_pkg::*;

  addr_t imm;
  addr_t int_a;
  addr_t int_b;

  // Integer views of the two register reads
  assign int_a = get_addr(rdata_a_i);
  assign int_b = get_addr(rdata_b_i);

  always_comb begin
    unique case (ctrl_i.imm_sel)
      IMM_S:   imm = imm_s_i;
      IMM_U:   imm = imm_u_i;
      default: imm = imm_i_i;
    endcase
  end

  ////////////////////////////////////////
  // EX operands
  ////////////////////////////////////////

  assign ex_req_o.alu_op    = ctrl_i.alu_op;
  assign ex_req_o.operand_a = (ctrl_i.op_a_sel == OP_A_ZERO) ? '0 : int_a;
  assign ex_req_o.operand_b = (ctrl_i.op_b_sel == OP_B_IMM) ? imm : int_b;

  assign mult_a_o = int_a;
  assign mult_b_o = int_b;

  ////////////////////////////////////////
  // LSU and capability ALU operands
  ////////////////////////////////////////

  // Integer-mode accesses are relative to DDC
  assign mem_o.req   = 1'b0;
  assign mem_o.we    = ctrl_i.data_we;
  assign mem_o.base  = cap_mode_i ? rdata_a_i : ddc_i;
  assign mem_o.wdata = rdata_b_i;

  // c0 as a base names DDC
  assign cap_a_o = (raddr_a_i == '0) ? ddc_i : rdata_a_i;

  // PCC sits on B when no immediate is needed
  assign cap_b_o = (ctrl_i.cap_op == CAP_INCOFFSET) ? null_with_addr(imm_i_i) : pc_cap_i;

endmodule

`default_nettype wire

// File: design/cap_register_file.sv
// Capability-wide register file, two combinational read ports and one write port
`timescale 1ns/10ps
`default_nettype none

module cap_register_file #(
  parameter bit RV32E = 1'b0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  cap_id_pkg::reg_addr_t raddr_a_i,
  input  cap_id_pkg::reg_addr_t raddr_b_i,
  input  cap_id_pkg::reg_addr_t waddr_i,
  input  cap_id_pkg::cap_t      wdata_i,
  input  logic                  we_i,
  output cap_id_pkg::cap_t      rdata_a_o,
  output cap_id_pkg::cap_t      rdata_b_o
);

  import cap_id_pkg::*;

  localparam int unsigned IdxW    = RV32E ? 4 : 5;
  localparam int unsigned NumRegs = 2 ** IdxW;

  cap_t regs [NumRegs];

  // Entry zero is never written and stays a null capability
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= null_with_addr('0);
      end
    end else begin
      for (int i = 1; i < NumRegs; i++) begin
        if (we_i && (waddr_i[IdxW-1:0] == i)) begin
          regs[i] <= wdata_i;
        end
      end
    end
  end

  assign rdata_a_o = regs[raddr_a_i[IdxW-1:0]];
  assign rdata_b_o = regs[raddr_b_i[IdxW-1:0]];

endmodule

`default_nettype wire

// File: design/cap_decoder.sv
// Instruction decoder of the decode stage, turns an instruction word into control and operands
`timescale 1ns/10ps
`default_nettype none

module cap_decoder #(
  parameter bit RV32E = 1'b0,
  parameter bit RV32M = 1'b1
) (
  input  cap_id_pkg::addr_t     instr_rdata_i,
  input  logic                  cap_mode_i,
  output cap_id_pkg::dec_ctrl_t ctrl_o,
  output cap_id_pkg::reg_addr_t raddr_a_o,
  output cap_id_pkg::reg_addr_t raddr_b_o,
  output cap_id_pkg::reg_addr_t waddr_o,
  output cap_id_pkg::addr_t     imm_i_o,
  output cap_id_pkg::addr_t     imm_s_o,
  output cap_id_pkg::addr_t     imm_u_o,
  output logic [6:0]            cap_funct_o
);

  import cap_id_pkg::*;

  localparam logic [6:0] OpcOp    = 7'b0110011;
  localparam logic [6:0] OpcOpImm = 7'b0010011;
  localparam logic [6:0] OpcLui   = 7'b0110111;
  localparam logic [6:0] OpcLoad  = 7'b0000011;
  localparam logic [6:0] OpcStore = 7'b0100011;
  localparam logic [6:0] OpcCap   = 7'b1011011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       alt_op;
  logic       rs1_used;
  logic       rs2_used;
  alu_op_e    arith_op;

  assign opcode      = instr_rdata_i[6:0];
  assign funct3      = instr_rdata_i[14:12];
  assign funct7      = instr_rdata_i[31:25];
  assign raddr_a_o   = instr_rdata_i[19:15];
  assign raddr_b_o   = instr_rdata_i[24:20];
  assign waddr_o     = instr_rdata_i[11:7];
  assign cap_funct_o = funct7;

  assign imm_i_o = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_s_o = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
  assign imm_u_o = {instr_rdata_i[31:12], 12'b0};

  // SUB only exists as a register op, SRA in both forms
  assign alt_op = funct7[5] & ((opcode == OpcOp) | (funct3 == 3'b101));

  always_comb begin
    unique case (funct3)
      3'b000:  arith_op = alt_op ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = alt_op ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    ctrl_o   = '0;
    rs1_used = 1'b0;
    rs2_used = 1'b0;
    unique case (opcode)
      OpcOp: begin
        rs1_used      = 1'b1;
        rs2_used      = 1'b1;
        ctrl_o.reg_we = 1'b1;
        ctrl_o.alu_op = arith_op;
        if (funct7 == 7'b0000001) begin
          ctrl_o.mult_en = 1'b1;
          ctrl_o.illegal = (funct3 != 3'b000) || !RV32M;
        end else begin
          ctrl_o.illegal = !((funct7 == 7'b0) ||
                             (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
        end
      end
      OpcOpImm: begin
        rs1_used        = 1'b1;
        ctrl_o.reg_we   = 1'b1;
        ctrl_o.alu_op   = arith_op;
        ctrl_o.op_b_sel = OP_B_IMM;
        // Shift amounts leave funct7 as an encoding field
        if (funct3 == 3'b001) begin
          ctrl_o.illegal = (funct7 != 7'b0);
        end else if (funct3 == 3'b101) begin
          ctrl_o.illegal = (funct7 != 7'b0) && (funct7 != 7'b0100000);
        end
      end
      OpcLui: begin
        ctrl_o.reg_we   = 1'b1;
        ctrl_o.op_a_sel = OP_A_ZERO;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.imm_sel  = IMM_U;
      end
      OpcLoad, OpcStore: begin
        // ALU forms the address, rs1 capability is the base only in capability mode
        rs1_used        = 1'b1;
        rs2_used        = (opcode == OpcStore);
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.imm_sel  = (opcode == OpcStore) ? IMM_S : IMM_I;
        ctrl_o.reg_we   = (opcode == OpcLoad);
        ctrl_o.wd_sel   = WD_LSU;
        ctrl_o.data_req = 1'b1;
        ctrl_o.data_we  = (opcode == OpcStore);
        ctrl_o.cap_a_en = cap_mode_i;
        ctrl_o.cap_b_en = cap_mode_i && (opcode == OpcStore);
        ctrl_o.illegal  = (funct3 != 3'b010);
      end
      OpcCap: begin
        rs1_used        = 1'b1;
        ctrl_o.reg_we   = 1'b1;
        ctrl_o.wd_sel   = WD_CAP;
        ctrl_o.cap_a_en = 1'b1;
        if (funct3 == 3'b001) begin
          ctrl_o.cap_op = CAP_INCOFFSET;
        end else if (funct3 == 3'b000 && funct7 == 7'h7f && raddr_b_o == 5'h0f) begin
          ctrl_o.cap_op = CAP_GETADDR;
        end else begin
          ctrl_o.illegal = 1'b1;
        end
      end
      default: ctrl_o.illegal = 1'b1;
    endcase

    // Upper half of the register file is absent in RV32E
    if (RV32E && ((ctrl_o.reg_we && waddr_o[4]) || (rs1_used && raddr_a_o[4]) ||
                  (rs2_used && raddr_b_o[4]))) begin
      ctrl_o.illegal = 1'b1;
    end
    if (ctrl_o.illegal) begin
      ctrl_o.data_req = 1'b0;
      ctrl_o.data_we  = 1'b0;
      ctrl_o.mult_en  = 1'b0;
      ctrl_o.cap_op   = CAP_NONE;
    end
  end

endmodule

`default_nettype wire

// File: design/cap_id_pkg.sv
// Shared widths, types and capability helpers, imported by every module of the decode stage
`default_nettype none

package cap_id_pkg;

  parameter int unsigned CapW  = 93;
  parameter int unsigned AddrW = 32;
  parameter int unsigned ExcW  = 22;

  // Tag in the top bit, address in the low AddrW bits
  typedef logic [CapW-1:0]  cap_t;
  typedef logic [AddrW-1:0] addr_t;
  typedef logic [4:0]       reg_addr_t;
  // Top two bits are the call and return trap bits
  typedef logic [ExcW-1:0]  exc_vec_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
  } alu_op_e;

  typedef enum logic { OP_A_REG, OP_A_ZERO } op_a_sel_e;
  typedef enum logic { OP_B_REG, OP_B_IMM } op_b_sel_e;
  typedef enum logic [1:0] { IMM_I, IMM_S, IMM_U } imm_sel_e;
  typedef enum logic [1:0] { CAP_NONE, CAP_INCOFFSET, CAP_GETADDR } cap_op_e;
  typedef enum logic [1:0] { WD_EX, WD_LSU, WD_CAP } wd_sel_e;
  typedef enum logic { IDLE, WAIT_MULTICYCLE } id_fsm_e;

  typedef struct packed {
    alu_op_e   alu_op;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    imm_sel_e  imm_sel;
    logic      reg_we;
    wd_sel_e   wd_sel;
    logic      data_req;
    logic      data_we;
    logic      mult_en;
    cap_op_e   cap_op;
    logic      cap_a_en;
    logic      cap_b_en;
    logic      illegal;
  } dec_ctrl_t;

  typedef struct packed {
    alu_op_e alu_op;
    addr_t   operand_a;
    addr_t   operand_b;
  } ex_req_t;

  typedef struct packed {
    logic req;
    logic we;
    cap_t base;
    cap_t wdata;
  } mem_req_t;

  // Untagged capability carrying only an integer value
  function automatic cap_t null_with_addr(addr_t addr);
    cap_t cap;
    cap = '0;
    cap[AddrW-1:0] = addr;
    return cap;
  endfunction

  function automatic addr_t get_addr(cap_t cap);
    return cap[AddrW-1:0];
  endfunction

endpackage

`default_nettype wire
